// ==== rtl/cfg_bus_pkg.sv ====
package cfg_bus_pkg;

        //////////////////////////////
        // host side word sizes
        //////////////////////////////

        localparam int CFG_DATA_W = 16;
        localparam int CFG_ADDR_W = 16;

        //////////////////////////////
        // request vector layout
        //////////////////////////////

        // one bit per table in i_wr and i_rd
        localparam int IDX_TSS  = 0;
        localparam int IDX_TIS  = 1;
        localparam int IDX_FLT  = 2;
        localparam int IDX_QGC0 = 3; // qgc tables count up from here

        // host read word, decoded per table kind
        typedef union packed {
                logic [CFG_DATA_W-1:0] full;    // tss / tis entry
                struct packed {
                        logic [6:0] pad;
                        logic [8:0] entry;
                } flt;                          // filter entry
                struct packed {
                        logic [7:0] pad;
                        logic [7:0] entry;
                } qgc;                          // gate control entry
        } cfg_word_u;

endpackage

// ==== rtl/table_ram_pkg.sv ====
package table_ram_pkg;

        //////////////////////////////
        // address widths
        //////////////////////////////

        localparam int TSS_AW = 10;     // time slot table
        localparam int TIS_AW = 10;     // time interval table
        localparam int FLT_AW = 14;     // filter table
        localparam int QGC_AW = 10;     // per queue gate control

        //////////////////////////////
        // data widths
        //////////////////////////////

        localparam int TSS_DW = 16;
        localparam int TIS_DW = 16;
        localparam int FLT_DW = 9;
        localparam int QGC_DW = 8;

        //////////////////////////////
        // table count
        //////////////////////////////

        // tss, tis and flt sit below the qgc tables
        localparam int NUM_FIXED_TABLES = 3;

        // upper bound on the number of queue gate tables
        localparam int MAX_QGC = 8;

endpackage

// ==== rtl/cfg_request_decode.sv ====
`timescale 1ns/1ps

module cfg_request_decode
        import table_ram_pkg::*;
#(
        parameter int NUM_QGC = 4,
        localparam int REQ_W  = NUM_FIXED_TABLES + NUM_QGC
) (
        input  logic             i_clk,
        input  logic             i_rst_n,

        input  logic [REQ_W-1:0] i_wr,            // host write request, one bit per table
        input  logic [REQ_W-1:0] i_rd,            // host read request

        output logic [REQ_W-1:0] o_wr_grant,      // one hot
        output logic [REQ_W-1:0] o_rd_issue,
        output logic             o_rd_active,
        output logic [REQ_W-1:0] o_rd_return_sel  // issued reads, three cycles later
);

        logic [REQ_W-1:0] wr_grant;
        logic [REQ_W-1:0] rd_issue;
        logic [REQ_W-1:0] rd_issue_d1;
        logic [REQ_W-1:0] rd_issue_d2;
        logic [REQ_W-1:0] rd_issue_d3;

        // the bridge only supports 1 to MAX_QGC gate tables
        if (NUM_QGC < 1 || NUM_QGC > MAX_QGC) begin : g_bad_num_qgc
                $fatal(1, "cfg_request_decode: NUM_QGC out of range");
        end

        //////////////////////////////
        // write grant
        //////////////////////////////

        // two's complement trick keeps only the lowest set bit
        assign wr_grant   = i_wr & (~i_wr + 1'b1);
        assign o_wr_grant = wr_grant;

        //////////////////////////////
        // read issue
        //////////////////////////////

        // a table being written this cycle can not also be read
        assign rd_issue    = i_rd & ~wr_grant;
        assign o_rd_issue  = rd_issue;

        // level seen by every port, steers the address mux
        assign o_rd_active = |i_rd;

        //////////////////////////////
        // return alignment
        //////////////////////////////

        // d1 lines up with the registered strobe at the table,
        // d3 with the ram output two cycles after that
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        rd_issue_d1 <= '0;
                        rd_issue_d2 <= '0;
                        rd_issue_d3 <= '0;
                end else begin
                        rd_issue_d1 <= rd_issue;
                        rd_issue_d2 <= rd_issue_d1;
                        rd_issue_d3 <= rd_issue_d2;
                end
        end

        assign o_rd_return_sel = rd_issue_d3;

endmodule

// ==== rtl/table_port.sv ====
`timescale 1ns/1ps

module table_port
        import cfg_bus_pkg::*;
#(
        parameter int ADDR_W = 10,
        parameter int DATA_W = 16
) (
        input  logic                  i_clk,
        input  logic                  i_rst_n,

        input  logic [CFG_ADDR_W-1:0] i_waddr,
        input  logic [CFG_ADDR_W-1:0] i_raddr,
        input  logic [CFG_DATA_W-1:0] i_wdata,
        input  logic                  i_wr_grant,   // this table won the write
        input  logic                  i_rd_issue,   // read for this table, already masked
        input  logic                  i_rd_active,  // some read is pending on the bus

        output logic [ADDR_W-1:0]     o_ram_addr,
        output logic [DATA_W-1:0]     o_ram_wdata,
        output logic                  o_ram_wr,
        output logic                  o_ram_rd
);

        //////////////////////////////
        // address and data
        //////////////////////////////

        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_ram_addr  <= '0;
                        o_ram_wdata <= '0;
                end else if (i_wr_grant) begin
                        o_ram_addr  <= i_waddr[ADDR_W-1:0];
                        o_ram_wdata <= i_wdata[DATA_W-1:0];
                end else if (i_rd_active) begin
                        o_ram_addr  <= i_raddr[ADDR_W-1:0]; // wdata keeps last write
                end
        end

        //////////////////////////////
        // strobes
        //////////////////////////////

        // rebuilt every cycle, so each one is a single cycle pulse
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_ram_wr <= 1'b0;
                        o_ram_rd <= 1'b0;
                end else begin
                        o_ram_wr <= i_wr_grant;
                        o_ram_rd <= i_rd_issue;
                end
        end

endmodule

// ==== rtl/read_return_mux.sv ====
`timescale 1ns/1ps

module read_return_mux
        import cfg_bus_pkg::*;
        import table_ram_pkg::*;
#(
        parameter int NUM_QGC = 4,
        localparam int REQ_W  = NUM_FIXED_TABLES + NUM_QGC
) (
        input  logic                  i_clk,
        input  logic                  i_rst_n,

        input  logic [REQ_W-1:0]      i_rd_return_sel,

        input  logic [TSS_DW-1:0]     i_tss_ram_rdata,
        input  logic [TIS_DW-1:0]     i_tis_ram_rdata,
        input  logic [FLT_DW-1:0]     i_flt_ram_rdata,
        input  logic [QGC_DW-1:0]     i_qgc_ram_rdata [NUM_QGC],

        output logic [CFG_DATA_W-1:0] o_rdata
);

        cfg_word_u ret_word;
        logic      sel_onehot;

        // exactly one table returning this cycle
        assign sel_onehot = (i_rd_return_sel != '0) &&
                            ((i_rd_return_sel & (i_rd_return_sel - 1'b1)) == '0);

        //////////////////////////////
        // word build
        //////////////////////////////

        always_comb begin
                ret_word = '0;
                if (i_rd_return_sel[IDX_TSS]) begin
                        ret_word.full = i_tss_ram_rdata;
                end else if (i_rd_return_sel[IDX_TIS]) begin
                        ret_word.full = i_tis_ram_rdata;
                end else if (i_rd_return_sel[IDX_FLT]) begin
                        ret_word.flt.pad   = '0;
                        ret_word.flt.entry = i_flt_ram_rdata;
                end
                // narrow gate entries, zero above
                for (int q = 0; q < NUM_QGC; q++) begin
                        if (i_rd_return_sel[IDX_QGC0+q]) begin
                                ret_word.qgc.pad   = '0;
                                ret_word.qgc.entry = i_qgc_ram_rdata[q];
                        end
                end
        end

        //////////////////////////////
        // output register
        //////////////////////////////

        // no return or a multi hot return leaves the host word alone
        always_ff @(posedge i_clk or negedge i_rst_n) begin
                if (!i_rst_n) begin
                        o_rdata <= '0;
                end else if (sel_onehot) begin
                        o_rdata <= ret_word.full;
                end
        end

endmodule

// ==== rtl/cfg_ram_bridge.sv ====
`timescale 1ns/1ps

module cfg_ram_bridge
        import cfg_bus_pkg::*;
        import table_ram_pkg::*;
#(
        parameter int NUM_QGC = 4,
        localparam int REQ_W  = NUM_FIXED_TABLES + NUM_QGC
) (
        input  logic                  i_clk,
        input  logic                  i_rst_n,

        // host port
        input  logic [CFG_DATA_W-1:0] i_wdata,
        input  logic [CFG_ADDR_W-1:0] i_waddr,
        input  logic [REQ_W-1:0]      i_wr,
        input  logic [CFG_ADDR_W-1:0] i_raddr,
        input  logic [REQ_W-1:0]      i_rd,
        output logic [CFG_DATA_W-1:0] o_rdata,

        // time slot table
        output logic [TSS_AW-1:0]     o_tss_ram_addr,
        output logic [TSS_DW-1:0]     o_tss_ram_wdata,
        output logic                  o_tss_ram_wr,
        output logic                  o_tss_ram_rd,
        input  logic [TSS_DW-1:0]     i_tss_ram_rdata,

        // time interval table
        output logic [TIS_AW-1:0]     o_tis_ram_addr,
        output logic [TIS_DW-1:0]     o_tis_ram_wdata,
        output logic                  o_tis_ram_wr,
        output logic                  o_tis_ram_rd,
        input  logic [TIS_DW-1:0]     i_tis_ram_rdata,

        // filter table
        output logic [FLT_AW-1:0]     o_flt_ram_addr,
        output logic [FLT_DW-1:0]     o_flt_ram_wdata,
        output logic                  o_flt_ram_wr,
        output logic                  o_flt_ram_rd,
        input  logic [FLT_DW-1:0]     i_flt_ram_rdata,

        // queue gate control tables
        output logic [QGC_AW-1:0]     o_qgc_ram_addr  [NUM_QGC],
        output logic [QGC_DW-1:0]     o_qgc_ram_wdata [NUM_QGC],
        output logic [NUM_QGC-1:0]    o_qgc_ram_wr,
        output logic [NUM_QGC-1:0]    o_qgc_ram_rd,
        input  logic [QGC_DW-1:0]     i_qgc_ram_rdata [NUM_QGC]
);

        logic [REQ_W-1:0] wr_grant;
        logic [REQ_W-1:0] rd_issue;
        logic             rd_active;
        logic [REQ_W-1:0] rd_return_sel;

        //////////////////////////////
        // request decode
        //////////////////////////////

        cfg_request_decode #(.NUM_QGC(NUM_QGC)) u_decode (
                .i_clk           (i_clk),
                .i_rst_n         (i_rst_n),
                .i_wr            (i_wr),
                .i_rd            (i_rd),
                .o_wr_grant      (wr_grant),
                .o_rd_issue      (rd_issue),
                .o_rd_active     (rd_active),
                .o_rd_return_sel (rd_return_sel)
        );

        //////////////////////////////
        // table ports
        //////////////////////////////

        table_port #(.ADDR_W(TSS_AW), .DATA_W(TSS_DW)) u_tss_port (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_waddr     (i_waddr),
                .i_raddr     (i_raddr),
                .i_wdata     (i_wdata),
                .i_wr_grant  (wr_grant[IDX_TSS]),
                .i_rd_issue  (rd_issue[IDX_TSS]),
                .i_rd_active (rd_active),
                .o_ram_addr  (o_tss_ram_addr),
                .o_ram_wdata (o_tss_ram_wdata),
                .o_ram_wr    (o_tss_ram_wr),
                .o_ram_rd    (o_tss_ram_rd)
        );

        table_port #(.ADDR_W(TIS_AW), .DATA_W(TIS_DW)) u_tis_port (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_waddr     (i_waddr),
                .i_raddr     (i_raddr),
                .i_wdata     (i_wdata),
                .i_wr_grant  (wr_grant[IDX_TIS]),
                .i_rd_issue  (rd_issue[IDX_TIS]),
                .i_rd_active (rd_active),
                .o_ram_addr  (o_tis_ram_addr),
                .o_ram_wdata (o_tis_ram_wdata),
                .o_ram_wr    (o_tis_ram_wr),
                .o_ram_rd    (o_tis_ram_rd)
        );

        table_port #(.ADDR_W(FLT_AW), .DATA_W(FLT_DW)) u_flt_port (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_waddr     (i_waddr),
                .i_raddr     (i_raddr),
                .i_wdata     (i_wdata),
                .i_wr_grant  (wr_grant[IDX_FLT]),
                .i_rd_issue  (rd_issue[IDX_FLT]),
                .i_rd_active (rd_active),
                .o_ram_addr  (o_flt_ram_addr),
                .o_ram_wdata (o_flt_ram_wdata),
                .o_ram_wr    (o_flt_ram_wr),
                .o_ram_rd    (o_flt_ram_rd)
        );

        for (genvar q = 0; q < NUM_QGC; q++) begin : g_qgc_port
                table_port #(.ADDR_W(QGC_AW), .DATA_W(QGC_DW)) u_qgc_port (
                        .i_clk       (i_clk),
                        .i_rst_n     (i_rst_n),
                        .i_waddr     (i_waddr),
                        .i_raddr     (i_raddr),
                        .i_wdata     (i_wdata),
                        .i_wr_grant  (wr_grant[IDX_QGC0+q]),
                        .i_rd_issue  (rd_issue[IDX_QGC0+q]),
                        .i_rd_active (rd_active),
                        .o_ram_addr  (o_qgc_ram_addr[q]),
                        .o_ram_wdata (o_qgc_ram_wdata[q]),
                        .o_ram_wr    (o_qgc_ram_wr[q]),
                        .o_ram_rd    (o_qgc_ram_rd[q])
                );
        end

        //////////////////////////////
        // read return
        //////////////////////////////

        read_return_mux #(.NUM_QGC(NUM_QGC)) u_return_mux (
                .i_clk           (i_clk),
                .i_rst_n         (i_rst_n),
                .i_rd_return_sel (rd_return_sel),
                .i_tss_ram_rdata (i_tss_ram_rdata),
                .i_tis_ram_rdata (i_tis_ram_rdata),
                .i_flt_ram_rdata (i_flt_ram_rdata),
                .i_qgc_ram_rdata (i_qgc_ram_rdata),
                .o_rdata         (o_rdata)
        );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
        parameter int PERIOD_NS    = 100,
        parameter int RESET_CYCLES = 10
) (
        output logic o_clk,
        output logic o_rst_n
);

        initial begin
                o_clk = 1'b0;
                forever #(PERIOD_NS / 2) o_clk = ~o_clk;
        end

        initial begin
                o_rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge o_clk);
                #1 o_rst_n = 1'b1; // release just after the edge
        end

endmodule

// ==== dv/table_ram_model.sv ====
`timescale 1ns/1ps

module table_ram_model #(
        parameter int AW       = 10,
        parameter int DW       = 16,
        parameter int TABLE_ID = 0
) (
        input  logic          i_clk,
        input  logic [AW-1:0] i_addr,
        input  logic [DW-1:0] i_wdata,
        input  logic          i_wr,
        input  logic          i_rd,
        output logic [DW-1:0] o_rdata
);

        logic [DW-1:0] mem [1 << AW];
        logic [DW-1:0] rd_q;

        // preload, every address bit and the table id feed the pattern
        function automatic logic [15:0] fill_word(int id, int a);
                return 16'((a * 40503) ^ (id * 4099) ^ (a >> 5));
        endfunction

        initial begin
                logic [15:0] w;
                for (int a = 0; a < (1 << AW); a++) begin
                        w = fill_word(TABLE_ID, a);
                        mem[a] = w[DW-1:0];
                end
                rd_q    = '0;
                o_rdata = '0;
        end

        // two stage read, data out two edges after the strobe
        always @(posedge i_clk) begin
                if (i_wr) mem[i_addr] <= i_wdata;
                if (i_rd) rd_q <= mem[i_addr];
                o_rdata <= rd_q;
        end

endmodule

// ==== dv/bridge_scoreboard.sv ====
`timescale 1ns/1ps

module bridge_scoreboard
        import table_ram_pkg::*;
#(
        parameter int NUM_QGC = 4,
        localparam int NT     = NUM_FIXED_TABLES + NUM_QGC
) (
        input  logic          i_clk,
        input  logic          i_rst_n,
        input  logic [NT-1:0] i_wr,
        input  logic [NT-1:0] i_rd,
        input  logic [15:0]   i_waddr,
        input  logic [15:0]   i_raddr,
        input  logic [15:0]   i_wdata,
        input  logic [NT-1:0] i_ram_wr,
        input  logic [NT-1:0] i_ram_rd,
        input  logic [15:0]   i_ram_addr  [NT],
        input  logic [15:0]   i_ram_wdata [NT],
        input  logic [15:0]   i_rdata,
        output int            o_strobe_errs,
        output int            o_port_errs,
        output int            o_read_errs,
        output int            o_reads_checked,
        output logic          o_idle
);

        logic [15:0]   shadow [int];  // key is table * 65536 + address
        logic [NT-1:0] prev_wr, prev_rd, grant, issue;
        logic [15:0]   prev_waddr, prev_raddr, prev_wdata, exp_rdata, rd_val;
        logic [15:0]   exp_addr [NT];
        logic [15:0]   exp_wdata [NT];
        logic [NT-1:0] pipe_sel [4];  // one stage per cycle from read strobe to o_rdata
        logic [15:0]   pipe_val [4];

        function automatic int addr_w(int t);
                return (t == 0) ? TSS_AW : (t == 1) ? TIS_AW : (t == 2) ? FLT_AW : QGC_AW;
        endfunction

        function automatic int data_w(int t);
                return (t == 0) ? TSS_DW : (t == 1) ? TIS_DW : (t == 2) ? FLT_DW : QGC_DW;
        endfunction

        function automatic logic [15:0] narrow(logic [15:0] v, int w);
                return v & 16'((32'd1 << w) - 1);
        endfunction

        function automatic logic [15:0] mem_read(int t, logic [15:0] a);
                int key;
                key = t * 65536 + int'(a);
                if (shadow.exists(key)) return shadow[key];
                return narrow(16'((a * 40503) ^ (t * 4099) ^ (a >> 5)), data_w(t));
        endfunction

        // first set bit from bit 0 upward wins
        function automatic logic [NT-1:0] lowest_bit(logic [NT-1:0] v);
                for (int i = 0; i < NT; i++) begin
                        if (v[i]) return NT'(1) << i;
                end
                return '0;
        endfunction

        // checked at the negedge where outputs hold the request taken at the last posedge
        always @(negedge i_clk) begin
                if (!i_rst_n) begin
                        prev_wr    = '0;
                        prev_rd    = '0;
                        prev_waddr = '0;
                        prev_raddr = '0;
                        prev_wdata = '0;
                        exp_rdata  = '0;
                        for (int t = 0; t < NT; t++) begin
                                exp_addr[t]  = '0;
                                exp_wdata[t] = '0;
                        end
                        for (int s = 0; s < 4; s++) begin
                                pipe_sel[s] = '0;
                                pipe_val[s] = '0;
                        end
                        o_idle = 1'b1;
                end else begin
                        grant  = lowest_bit(prev_wr);
                        issue  = prev_rd & ~grant;
                        rd_val = '0;
                        for (int t = 0; t < NT; t++) begin
                                if (grant[t]) begin
                                        exp_addr[t]  = narrow(prev_waddr, addr_w(t));
                                        exp_wdata[t] = narrow(prev_wdata, data_w(t));
                                        shadow[t * 65536 + int'(exp_addr[t])] = exp_wdata[t];
                                end else if (prev_rd != '0) begin
                                        exp_addr[t] = narrow(prev_raddr, addr_w(t));
                                end
                                if (issue[t]) rd_val = mem_read(t, exp_addr[t]);
                        end
                        for (int s = 3; s > 0; s--) begin
                                pipe_sel[s] = pipe_sel[s-1];
                                pipe_val[s] = pipe_val[s-1];
                        end
                        pipe_sel[0] = issue;
                        pipe_val[0] = rd_val;
                        if ($countones(pipe_sel[3]) == 1) begin
                                exp_rdata = pipe_val[3];
                                o_reads_checked++;
                        end

                        if (i_ram_wr !== grant) begin
                                $display("mismatch write strobe expected %h actual %h",
                                         grant, i_ram_wr);
                                o_strobe_errs++;
                        end
                        if (i_ram_rd !== issue) begin
                                $display("mismatch read strobe expected %h actual %h",
                                         issue, i_ram_rd);
                                o_strobe_errs++;
                        end
                        for (int t = 0; t < NT; t++) begin
                                if (i_ram_addr[t] !== exp_addr[t]) begin
                                        $display("mismatch table %0d addr expected %h actual %h",
                                                 t, exp_addr[t], i_ram_addr[t]);
                                        o_port_errs++;
                                end
                                if (i_ram_wdata[t] !== exp_wdata[t]) begin
                                        $display("mismatch table %0d wdata expected %h actual %h",
                                                 t, exp_wdata[t], i_ram_wdata[t]);
                                        o_port_errs++;
                                end
                        end
                        if (i_rdata !== exp_rdata) begin
                                $display("mismatch read data expected %h actual %h",
                                         exp_rdata, i_rdata);
                                o_read_errs++;
                        end

                        prev_wr    = i_wr;
                        prev_rd    = i_rd;
                        prev_waddr = i_waddr;
                        prev_raddr = i_raddr;
                        prev_wdata = i_wdata;
                        o_idle = (prev_rd == '0) && (pipe_sel[0] == '0)
                                 && (pipe_sel[1] == '0) && (pipe_sel[2] == '0);
                end
        end

        initial begin
                o_strobe_errs   = 0;
                o_port_errs     = 0;
                o_read_errs     = 0;
                o_reads_checked = 0;
        end

endmodule

// ==== dv/bridge_checker.sv ====
`timescale 1ns/1ps

module bridge_checker
        import table_ram_pkg::*;
#(
        parameter int NUM_QGC = 4,
        localparam int NT     = NUM_FIXED_TABLES + NUM_QGC
) (
        input logic          i_clk,
        input logic          i_rst_n,
        input logic [NT-1:0] i_wr_strb,
        input logic [NT-1:0] i_rd_strb
);

        int assert_errs = 0;

        a_single_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                $onehot0(i_wr_strb))
        else begin
                assert_errs++;
                $error("write strobes active on more than one table");
        end

        a_no_wr_and_rd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                (i_wr_strb & i_rd_strb) == '0)
        else begin
                assert_errs++;
                $error("table got a write and a read strobe in one cycle");
        end

        // async reset, strobes must already be low at the edge
        a_reset_quiet: assert property (@(posedge i_clk)
                !i_rst_n |-> (i_wr_strb == '0 && i_rd_strb == '0))
        else begin
                assert_errs++;
                $error("strobe active while in reset");
        end

endmodule

// ==== dv/tb_cfg_ram_bridge.sv ====
`timescale 1ns/1ps

module tb_cfg_ram_bridge
        import table_ram_pkg::*;
;
        localparam int NUM_QGC = 4;
        localparam int NT      = NUM_FIXED_TABLES + NUM_QGC;
        localparam int NUM_TXN = 3000;

        logic clk, rst_n;
        logic [15:0] wdata, waddr, raddr, rdata;
        logic [NT-1:0] wr, rd, ram_wr_all, ram_rd_all;
        logic [15:0] addr_all [NT];
        logic [15:0] wdata_all [NT];
        logic [TSS_AW-1:0] tss_addr;
        logic [TSS_DW-1:0] tss_wdata, tss_rdata;
        logic tss_wr, tss_rd;
        logic [TIS_AW-1:0] tis_addr;
        logic [TIS_DW-1:0] tis_wdata, tis_rdata;
        logic tis_wr, tis_rd;
        logic [FLT_AW-1:0] flt_addr;
        logic [FLT_DW-1:0] flt_wdata, flt_rdata;
        logic flt_wr, flt_rd;
        logic [QGC_AW-1:0] qgc_addr [NUM_QGC];
        logic [QGC_DW-1:0] qgc_wdata [NUM_QGC];
        logic [QGC_DW-1:0] qgc_rdata [NUM_QGC];
        logic [NUM_QGC-1:0] qgc_wr, qgc_rd;
        int strobe_errs, port_errs, read_errs, reads_checked, timeouts, wait_cnt, total;
        logic sb_idle;

        tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(10)) u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

        cfg_ram_bridge #(.NUM_QGC(NUM_QGC)) i_cfg_ram_bridge (
                .i_clk(clk), .i_rst_n(rst_n),
                .i_wdata(wdata), .i_waddr(waddr), .i_wr(wr),
                .i_raddr(raddr), .i_rd(rd), .o_rdata(rdata),
                .o_tss_ram_addr(tss_addr), .o_tss_ram_wdata(tss_wdata), .o_tss_ram_wr(tss_wr),
                .o_tss_ram_rd(tss_rd), .i_tss_ram_rdata(tss_rdata),
                .o_tis_ram_addr(tis_addr), .o_tis_ram_wdata(tis_wdata), .o_tis_ram_wr(tis_wr),
                .o_tis_ram_rd(tis_rd), .i_tis_ram_rdata(tis_rdata),
                .o_flt_ram_addr(flt_addr), .o_flt_ram_wdata(flt_wdata), .o_flt_ram_wr(flt_wr),
                .o_flt_ram_rd(flt_rd), .i_flt_ram_rdata(flt_rdata),
                .o_qgc_ram_addr(qgc_addr), .o_qgc_ram_wdata(qgc_wdata), .o_qgc_ram_wr(qgc_wr),
                .o_qgc_ram_rd(qgc_rd), .i_qgc_ram_rdata(qgc_rdata)
        );

        bind cfg_ram_bridge bridge_checker #(.NUM_QGC(NUM_QGC)) u_checker (
                .i_clk(i_clk), .i_rst_n(i_rst_n),
                .i_wr_strb({o_qgc_ram_wr, o_flt_ram_wr, o_tis_ram_wr, o_tss_ram_wr}),
                .i_rd_strb({o_qgc_ram_rd, o_flt_ram_rd, o_tis_ram_rd, o_tss_ram_rd})
        );

        ////////////////////////////////
        // table rams
        ////////////////////////////////

        table_ram_model #(.AW(TSS_AW), .DW(TSS_DW), .TABLE_ID(0)) u_tss_ram (
                .i_clk(clk), .i_addr(tss_addr), .i_wdata(tss_wdata),
                .i_wr(tss_wr), .i_rd(tss_rd), .o_rdata(tss_rdata));
        table_ram_model #(.AW(TIS_AW), .DW(TIS_DW), .TABLE_ID(1)) u_tis_ram (
                .i_clk(clk), .i_addr(tis_addr), .i_wdata(tis_wdata),
                .i_wr(tis_wr), .i_rd(tis_rd), .o_rdata(tis_rdata));
        table_ram_model #(.AW(FLT_AW), .DW(FLT_DW), .TABLE_ID(2)) u_flt_ram (
                .i_clk(clk), .i_addr(flt_addr), .i_wdata(flt_wdata),
                .i_wr(flt_wr), .i_rd(flt_rd), .o_rdata(flt_rdata));

        assign addr_all[0]  = 16'(tss_addr);
        assign addr_all[1]  = 16'(tis_addr);
        assign addr_all[2]  = 16'(flt_addr);
        assign wdata_all[0] = 16'(tss_wdata);
        assign wdata_all[1] = 16'(tis_wdata);
        assign wdata_all[2] = 16'(flt_wdata);
        assign ram_wr_all   = {qgc_wr, flt_wr, tis_wr, tss_wr};
        assign ram_rd_all   = {qgc_rd, flt_rd, tis_rd, tss_rd};

        for (genvar q = 0; q < NUM_QGC; q++) begin : g_qgc_ram
                table_ram_model #(.AW(QGC_AW), .DW(QGC_DW), .TABLE_ID(3 + q)) u_qgc_ram (
                        .i_clk(clk), .i_addr(qgc_addr[q]), .i_wdata(qgc_wdata[q]),
                        .i_wr(qgc_wr[q]), .i_rd(qgc_rd[q]), .o_rdata(qgc_rdata[q]));
                assign addr_all[3 + q]  = 16'(qgc_addr[q]);
                assign wdata_all[3 + q] = 16'(qgc_wdata[q]);
        end

        bridge_scoreboard #(.NUM_QGC(NUM_QGC)) u_scoreboard (
                .i_clk(clk), .i_rst_n(rst_n), .i_wr(wr), .i_rd(rd),
                .i_waddr(waddr), .i_raddr(raddr), .i_wdata(wdata),
                .i_ram_wr(ram_wr_all), .i_ram_rd(ram_rd_all),
                .i_ram_addr(addr_all), .i_ram_wdata(wdata_all), .i_rdata(rdata),
                .o_strobe_errs(strobe_errs), .o_port_errs(port_errs), .o_read_errs(read_errs),
                .o_reads_checked(reads_checked), .o_idle(sb_idle)
        );

        ////////////////////////////////
        // stimulus
        ////////////////////////////////

        // mostly single bit vectors so reads actually return
        task automatic drive_random();
                int pick;
                pick = $urandom % 10;
                wr = (pick < 4) ? '0 : (pick < 8) ? NT'(1) << ($urandom % NT) : NT'($urandom);
                pick = $urandom % 20;
                if (pick < 10) rd = NT'(1) << ($urandom % NT);
                else if (pick < 13) rd = NT'($urandom);
                else if (pick < 16) rd = wr & ~(wr - 1'b1); // read the write target
                else rd = '0;
                waddr = 16'($urandom);
                raddr = 16'($urandom);
                wdata = 16'($urandom);
        endtask

        initial begin
                // every table is requested while reset is held
                wr    = '1;
                rd    = '1;
                waddr = '0;
                raddr = '0;
                wdata = '0;
                timeouts = 0;
                void'($urandom(32'h97b5));

                repeat (5) @(posedge clk);
                #1 begin
                        wr = '0;
                        rd = '0;
                end

                wait_cnt = 0;
                while (rst_n !== 1'b1 && wait_cnt < 50) begin
                        @(posedge clk);
                        wait_cnt++;
                end
                if (rst_n !== 1'b1) begin
                        $display("reset was never released");
                        timeouts++;
                end

                repeat (3) @(posedge clk); // outputs hold their reset values here
                for (int i = 0; i < NUM_TXN; i++) begin
                        @(posedge clk);
                        #1 drive_random();
                end
                @(posedge clk);
                #1 begin
                        wr = '0;
                        rd = '0;
                end

                wait_cnt = 0;
                while (!sb_idle && wait_cnt < 20) begin
                        @(posedge clk);
                        wait_cnt++;
                end
                if (!sb_idle) begin
                        $display("read pipeline did not drain");
                        timeouts++;
                end
                repeat (2) @(posedge clk);
                if (reads_checked == 0) begin
                        $display("no read return was ever checked");
                        timeouts++;
                end

                total = strobe_errs + port_errs + read_errs + timeouts
                        + i_cfg_ram_bridge.u_checker.assert_errs;
                $display("errors: strobe %0d port %0d read %0d assert %0d other %0d, reads %0d",
                         strobe_errs, port_errs, read_errs,
                         i_cfg_ram_bridge.u_checker.assert_errs, timeouts, reads_checked);
                if (total == 0) begin
                        $display("test passed");
                end else begin
                        $display("test failed");
                end
                $finish;
        end

endmodule

// ==== src.f ====
rtl/cfg_bus_pkg.sv
rtl/table_ram_pkg.sv
rtl/cfg_request_decode.sv
rtl/table_port.sv
rtl/read_return_mux.sv
rtl/cfg_ram_bridge.sv
dv/tb_clk_gen.sv
dv/table_ram_model.sv
dv/bridge_scoreboard.sv
dv/bridge_checker.sv
dv/tb_cfg_ram_bridge.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cfg_ram_bridge
FILELIST = src.f
BUILD    = obj_dir
SIM      = sim_$(TOP)
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(SIM)
	-./$(BUILD)/$(SIM) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
